//--- common/core_config.svh
//////////////////////////////////////////////////////////////////////
// Core sizing macros
//   Data path width, architectural register count and the
//   register address width derived from it
//////////////////////////////////////////////////////////////////////

`ifndef CORE_CONFIG_SVH
`define CORE_CONFIG_SVH

// Integer data path width
`define XLEN 32

// Architectural integer registers, x0 included
`define NUM_REGS 32
`define REG_ADDR_W 5

`endif

//--- common/riscv_types_pkg.sv
//////////////////////////////////////////////////////////////////////
// RV32I encoding definitions
//   Opcode and funct constants for the integer arithmetic groups
//   Field layouts of the R, I and U formats
//   Instruction word union over those formats
//////////////////////////////////////////////////////////////////////

`default_nettype none

`include "core_config.svh"

package riscv_types_pkg;

    // Major opcodes handled by the core
    localparam logic [6:0] OPCODE_OP     = 7'b0110011;
    localparam logic [6:0] OPCODE_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPCODE_LUI    = 7'b0110111;

    // funct3 selects the operation in OP and OP-IMM
    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLL     = 3'b001;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_SLTU    = 3'b011;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_SRL_SRA = 3'b101;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;

    // Only two funct7 values are legal and the second sets bit 30
    localparam logic [6:0] FUNCT7_BASE = 7'b0000000;
    localparam logic [6:0] FUNCT7_ALT  = 7'b0100000;

    typedef struct packed {
        logic [6:0]             funct7;
        logic [`REG_ADDR_W-1:0] rs2;
        logic [`REG_ADDR_W-1:0] rs1;
        logic [2:0]             funct3;
        logic [`REG_ADDR_W-1:0] rd;
        logic [6:0]             opcode;
    } r_type_t;

    typedef struct packed {
        logic [11:0]            imm12;
        logic [`REG_ADDR_W-1:0] rs1;
        logic [2:0]             funct3;
        logic [`REG_ADDR_W-1:0] rd;
        logic [6:0]             opcode;
    } i_type_t;

    typedef struct packed {
        logic [19:0]            imm20;
        logic [`REG_ADDR_W-1:0] rd;
        logic [6:0]             opcode;
    } u_type_t;

    // One word, read through whichever format the opcode calls for
    typedef union packed {
        r_type_t r;
        i_type_t i;
        u_type_t u;
    } instruction_t;

endpackage

`default_nettype wire

//--- common/core_types_pkg.sv
//////////////////////////////////////////////////////////////////////
// Core internal packet types
//   ALU operation encoding
//   Fetch, issue and writeback packets passed between stages
//////////////////////////////////////////////////////////////////////

`default_nettype none

`include "core_config.svh"

package core_types_pkg;

    typedef enum logic [3:0] {
        ALU_ADD  = 4'd0,
        ALU_SUB  = 4'd1,
        ALU_SLL  = 4'd2,
        ALU_SLT  = 4'd3,
        ALU_SLTU = 4'd4,
        ALU_XOR  = 4'd5,
        ALU_SRL  = 4'd6,
        ALU_SRA  = 4'd7,
        ALU_OR   = 4'd8,
        ALU_AND  = 4'd9
    } alu_op_t;

    // From the external fetch stage
    typedef struct packed {
        logic              valid;
        logic [`XLEN-1:0]  instruction;
    } fetch_packet_t;

    // Decoded instruction, registered by decode and consumed by the ALU
    typedef struct packed {
        logic                   valid;
        logic                   illegal;
        alu_op_t                alu_op;
        logic [`REG_ADDR_W-1:0] rd;
        logic [`REG_ADDR_W-1:0] rs1;
        logic [`REG_ADDR_W-1:0] rs2;
        logic                   uses_imm;
        logic [`XLEN-1:0]       imm;
    } issue_packet_t;

    typedef struct packed {
        logic                   valid;
        logic                   illegal;
        logic [`REG_ADDR_W-1:0] rd;
        logic [`XLEN-1:0]       data;
    } wb_packet_t;

endpackage

`default_nettype wire

//--- decode/decode_and_issue.sv
//////////////////////////////////////////////////////////////////////
// Decode and issue stage
//   Splits the instruction word into operands and an ALU operation,
//   builds the immediate and flags illegal encodings
//////////////////////////////////////////////////////////////////////

`default_nettype none

`include "core_config.svh"

module decode_and_issue
    import riscv_types_pkg::*;
    import core_types_pkg::*;
    (
        input logic clk,
        input logic rst,

        input fetch_packet_t fetch,
        output issue_packet_t issue
    );

    instruction_t instr;
    issue_packet_t issue_next;
    alu_op_t funct3_op;
    logic alt;
    logic funct7_ok;

    assign instr = fetch.instruction;
    assign alt = instr.r.funct7[5];

    // Bit 30 only allowed on SUB and the arithmetic right shift
    assign funct7_ok = (instr.r.funct7 == FUNCT7_BASE) ||
        ((instr.r.funct7 == FUNCT7_ALT) &&
        (instr.r.funct3 == F3_ADD_SUB || instr.r.funct3 == F3_SRL_SRA));

    // Operation common to OP and OP-IMM
    always_comb begin
        case (instr.r.funct3)
            F3_ADD_SUB: funct3_op = ALU_ADD;
            F3_SLL:     funct3_op = ALU_SLL;
            F3_SLT:     funct3_op = ALU_SLT;
            F3_SLTU:    funct3_op = ALU_SLTU;
            F3_XOR:     funct3_op = ALU_XOR;
            F3_SRL_SRA: funct3_op = alt ? ALU_SRA : ALU_SRL;
            F3_OR:      funct3_op = ALU_OR;
            default:    funct3_op = ALU_AND;
        endcase
    end

    ////////////////////////////////////////////////////////////////////
    // Packet build
    always_comb begin
        issue_next.valid = fetch.valid;
        issue_next.illegal = 1'b0;
        issue_next.alu_op = funct3_op;
        issue_next.rd = instr.r.rd;
        issue_next.rs1 = instr.r.rs1;
        issue_next.rs2 = instr.r.rs2;
        issue_next.uses_imm = 1'b0;
        issue_next.imm = {{(`XLEN-12){instr.i.imm12[11]}}, instr.i.imm12};

        case (instr.r.opcode)
            OPCODE_OP: begin
                if (instr.r.funct3 == F3_ADD_SUB && alt)
                    issue_next.alu_op = ALU_SUB;
                issue_next.illegal = ~funct7_ok;
            end
            OPCODE_OP_IMM: begin
                issue_next.uses_imm = 1'b1;
                issue_next.rs2 = '0;
                // Upper immediate bits act as funct7 on shifts only
                if (instr.i.funct3 == F3_SLL || instr.i.funct3 == F3_SRL_SRA)
                    issue_next.illegal = ~funct7_ok;
            end
            OPCODE_LUI: begin
                // LUI is x0 plus the shifted immediate
                issue_next.alu_op = ALU_ADD;
                issue_next.rs1 = '0;
                issue_next.rs2 = '0;
                issue_next.uses_imm = 1'b1;
                issue_next.imm = {instr.u.imm20, 12'b0};
            end
            default: begin
                issue_next.illegal = 1'b1;
            end
        endcase
    end

    ////////////////////////////////////////////////////////////////////
    // Issue register
    always_ff @(posedge clk) begin
        issue <= issue_next;
        if (rst)
            issue.valid <= 1'b0;
    end

endmodule

`default_nettype wire

//--- alu/alu_unit.sv
//////////////////////////////////////////////////////////////////////
// ALU execution unit
//   Operand read with bypass from the writeback register
//   Integer arithmetic, logic, compare and shift
//   Registered writeback packet
//////////////////////////////////////////////////////////////////////

`default_nettype none

`include "core_config.svh"

module alu_unit
    import core_types_pkg::*;
    (
        input logic clk,
        input logic rst,

        input issue_packet_t issue,

        output logic [`REG_ADDR_W-1:0] rs1_addr,
        output logic [`REG_ADDR_W-1:0] rs2_addr,
        input logic [`XLEN-1:0] rs1_data,
        input logic [`XLEN-1:0] rs2_data,

        output wb_packet_t wb
    );

    logic wb_forwardable;
    logic [`XLEN-1:0] rs1_value;
    logic [`XLEN-1:0] rs2_value;
    logic [`XLEN-1:0] operand_a;
    logic [`XLEN-1:0] operand_b;
    logic [4:0] shamt;
    logic [`XLEN-1:0] result;
    wb_packet_t wb_next;

    assign rs1_addr = issue.rs1;
    assign rs2_addr = issue.rs2;

    ////////////////////////////////////////////////////////////////////
    // Operands
    // Producer one cycle ahead has not reached the register file yet
    assign wb_forwardable = wb.valid & ~wb.illegal & (wb.rd != '0);

    assign rs1_value = (wb_forwardable && wb.rd == issue.rs1) ? wb.data : rs1_data;
    assign rs2_value = (wb_forwardable && wb.rd == issue.rs2) ? wb.data : rs2_data;

    assign operand_a = rs1_value;
    assign operand_b = issue.uses_imm ? issue.imm : rs2_value;
    assign shamt = operand_b[4:0];

    ////////////////////////////////////////////////////////////////////
    // Execute
    always_comb begin
        case (issue.alu_op)
            ALU_ADD:  result = operand_a + operand_b;
            ALU_SUB:  result = operand_a - operand_b;
            ALU_SLL:  result = operand_a << shamt;
            ALU_SLT:  result = {{(`XLEN-1){1'b0}}, $signed(operand_a) < $signed(operand_b)};
            ALU_SLTU: result = {{(`XLEN-1){1'b0}}, operand_a < operand_b};
            ALU_XOR:  result = operand_a ^ operand_b;
            ALU_SRL:  result = operand_a >> shamt;
            ALU_SRA:  result = $unsigned($signed(operand_a) >>> shamt);
            ALU_OR:   result = operand_a | operand_b;
            ALU_AND:  result = operand_a & operand_b;
            default:  result = '0;
        endcase
    end

    always_comb begin
        wb_next.valid = issue.valid;
        wb_next.illegal = issue.illegal;
        wb_next.rd = issue.rd;
        // Illegal instructions report zero data
        wb_next.data = issue.illegal ? '0 : result;
    end

    ////////////////////////////////////////////////////////////////////
    // Writeback register
    always_ff @(posedge clk) begin
        wb <= wb_next;
        if (rst)
            wb.valid <= 1'b0;
    end

endmodule

`default_nettype wire

//--- design/register_file.sv
//////////////////////////////////////////////////////////////////////
// Integer register file
//   Two combinational read ports, one write port from writeback,
//   x0 reads as zero
//////////////////////////////////////////////////////////////////////

`default_nettype none

`include "core_config.svh"

module register_file
    import core_types_pkg::*;
    (
        input logic clk,
        input logic rst,

        input logic [`REG_ADDR_W-1:0] rs1_addr,
        input logic [`REG_ADDR_W-1:0] rs2_addr,
        output logic [`XLEN-1:0] rs1_data,
        output logic [`XLEN-1:0] rs2_data,

        input wb_packet_t wb
    );

    logic [`XLEN-1:0] regs [`NUM_REGS];
    logic write_en;

    // x0 is never a target
    assign write_en = wb.valid & ~wb.illegal & (wb.rd != '0);

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `NUM_REGS; i++)
                regs[i] <= '0;
        end else if (write_en) begin
            regs[wb.rd] <= wb.data;
        end
    end

    assign rs1_data = (rs1_addr == '0) ? '0 : regs[rs1_addr];
    assign rs2_data = (rs2_addr == '0) ? '0 : regs[rs2_addr];

endmodule

`default_nettype wire

//--- design/rv_core.sv
//////////////////////////////////////////////////////////////////////
// Integer execution core top level
//   Decode and issue, ALU unit and register file
//   Two cycle latency from fetch strobe to writeback packet
//////////////////////////////////////////////////////////////////////

`default_nettype none

`include "core_config.svh"

module rv_core
    import core_types_pkg::*;
    (
        input logic clk,
        input logic rst,

        input fetch_packet_t fetch,
        output wb_packet_t wb
    );

    ////////////////////////////////////////////////////////////////////
    // Connecting signals
    issue_packet_t issue;

    logic [`REG_ADDR_W-1:0] rs1_addr;
    logic [`REG_ADDR_W-1:0] rs2_addr;
    logic [`XLEN-1:0] rs1_data;
    logic [`XLEN-1:0] rs2_data;

    ////////////////////////////////////////////////////////////////////
    // Decode/Issue
    decode_and_issue decode_and_issue_block (
        .clk (clk),
        .rst (rst),
        .fetch (fetch),
        .issue (issue)
    );

    ////////////////////////////////////////////////////////////////////
    // Execute stage and the writeback packet that leaves the core
    alu_unit alu_unit_block (
        .clk (clk),
        .rst (rst),
        .issue (issue),
        .rs1_addr (rs1_addr),
        .rs2_addr (rs2_addr),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .wb (wb)
    );

    register_file register_file_block (
        .clk (clk),
        .rst (rst),
        .rs1_addr (rs1_addr),
        .rs2_addr (rs2_addr),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .wb (wb)
    );

endmodule

`default_nettype wire

//--- tb/rv_core_tb.sv
//////////////////////////////////////////////////////////////////////
// Testbench for the integer execution core
//   Clock, reset, watchdog and a single value checker
//   Table of instructions with expected writeback, applied one row
//   per cycle and checked two edges later
//////////////////////////////////////////////////////////////////////

`default_nettype none

`include "core_config.svh"

module rv_core_tb
    import core_types_pkg::*;
    ();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int NUM_ROWS = 36;
    localparam int CLK_PERIOD = 40;

    // funct3 values as the RV32I manual lists them
    localparam logic [2:0] FN_ADD = 3'd0;
    localparam logic [2:0] FN_SLL = 3'd1;
    localparam logic [2:0] FN_SLT = 3'd2;
    localparam logic [2:0] FN_SLTU = 3'd3;
    localparam logic [2:0] FN_XOR = 3'd4;
    localparam logic [2:0] FN_SR = 3'd5;
    localparam logic [2:0] FN_OR = 3'd6;
    localparam logic [2:0] FN_AND = 3'd7;

    typedef struct packed {
        logic              valid;
        logic [`XLEN-1:0]  instr;
        logic [4:0]        rd;
        logic [`XLEN-1:0]  data;
        logic              illegal;
    } test_row_t;

    logic clk;
    logic rst;
    fetch_packet_t fetch;
    wb_packet_t wb;

    test_row_t rows [NUM_ROWS];
    int row_count = 0;
    int error_count = 0;
    int check_count = 0;
    int test_count = 0;
    integer seed = 32'ha23c;

    rv_core i_rv_core (
        .clk (clk),
        .rst (rst),
        .fetch (fetch),
        .wb (wb)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // Whole run is reset plus one cycle per row plus drain
    initial begin
        #((NUM_ROWS + 20) * CLK_PERIOD);
        $display("Timeout: the core did not get through the instruction table in time");
        $display("Verification failed");
        $finish;
    end

    ////////////////////////////////////////////////////////////////////
    // Instruction word builders
    function automatic logic [31:0] op_word(input logic [6:0] funct7, input logic [2:0] funct3,
                                            input logic [4:0] rd, input logic [4:0] rs1,
                                            input logic [4:0] rs2);
        return {funct7, rs2, rs1, funct3, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] op_imm_word(input logic [11:0] imm12, input logic [2:0] funct3,
                                                input logic [4:0] rd, input logic [4:0] rs1);
        return {imm12, rs1, funct3, rd, 7'b0010011};
    endfunction

    function automatic logic [31:0] lui_word(input logic [19:0] imm20, input logic [4:0] rd);
        return {imm20, rd, 7'b0110111};
    endfunction

    ////////////////////////////////////////////////////////////////////
    // Table building
    task automatic add_row(input logic [31:0] instr, input logic [4:0] rd,
                           input logic [31:0] data, input logic illegal);
        if (row_count < NUM_ROWS)
            rows[row_count] = '{1'b1, instr, rd, data, illegal};
        row_count++;
    endtask

    // Idle slot with noise in the instruction fields
    task automatic add_filler();
        if (row_count < NUM_ROWS)
            rows[row_count] = '{1'b0, $random(seed), 5'd0, 32'd0, 1'b0};
        row_count++;
    endtask

    task automatic load_table();
        // Immediate group builds the working values
        add_row(op_imm_word(12'd5, FN_ADD, 5'd1, 5'd0), 5'd1, 32'h0000_0005, 1'b0);
        add_row(op_imm_word(12'hffd, FN_ADD, 5'd2, 5'd0), 5'd2, 32'hffff_fffd, 1'b0);
        add_row(op_imm_word(12'h00f, FN_XOR, 5'd3, 5'd1), 5'd3, 32'h0000_000a, 1'b0);
        add_row(op_imm_word(12'h030, FN_OR, 5'd4, 5'd1), 5'd4, 32'h0000_0035, 1'b0);
        add_row(op_imm_word(12'h0f0, FN_AND, 5'd5, 5'd2), 5'd5, 32'h0000_00f0, 1'b0);
        add_row(op_imm_word(12'd1, FN_SLT, 5'd6, 5'd2), 5'd6, 32'h0000_0001, 1'b0);
        add_row(op_imm_word(12'd1, FN_SLTU, 5'd7, 5'd2), 5'd7, 32'h0000_0000, 1'b0);
        add_row(op_imm_word(12'd4, FN_SLL, 5'd8, 5'd1), 5'd8, 32'h0000_0050, 1'b0);
        add_row(op_imm_word(12'd28, FN_SR, 5'd9, 5'd2), 5'd9, 32'h0000_000f, 1'b0);
        add_row(op_imm_word(12'h401, FN_SR, 5'd10, 5'd2), 5'd10, 32'hffff_fffe, 1'b0);
        add_row(lui_word(20'h12345, 5'd11), 5'd11, 32'h1234_5000, 1'b0);
        add_filler();
        // Register-register group
        add_row(op_word(7'h00, FN_ADD, 5'd12, 5'd1, 5'd2), 5'd12, 32'h0000_0002, 1'b0);
        add_row(op_word(7'h20, FN_ADD, 5'd13, 5'd1, 5'd2), 5'd13, 32'h0000_0008, 1'b0);
        add_row(op_word(7'h00, FN_SLT, 5'd14, 5'd2, 5'd1), 5'd14, 32'h0000_0001, 1'b0);
        add_row(op_word(7'h00, FN_SLTU, 5'd15, 5'd2, 5'd1), 5'd15, 32'h0000_0000, 1'b0);
        add_row(op_word(7'h20, FN_SR, 5'd16, 5'd2, 5'd1), 5'd16, 32'hffff_ffff, 1'b0);
        add_row(op_word(7'h00, FN_SR, 5'd17, 5'd2, 5'd1), 5'd17, 32'h07ff_ffff, 1'b0);
        add_row(op_word(7'h00, FN_XOR, 5'd18, 5'd3, 5'd4), 5'd18, 32'h0000_003f, 1'b0);
        add_row(op_word(7'h00, FN_OR, 5'd19, 5'd5, 5'd11), 5'd19, 32'h1234_50f0, 1'b0);
        add_row(op_word(7'h00, FN_AND, 5'd20, 5'd11, 5'd2), 5'd20, 32'h1234_5000, 1'b0);
        add_row(op_word(7'h00, FN_SLL, 5'd21, 5'd1, 5'd1), 5'd21, 32'h0000_00a0, 1'b0);
        // Back to back chain, then a consumer two cycles behind
        add_row(op_imm_word(12'd1, FN_ADD, 5'd22, 5'd1), 5'd22, 32'h0000_0006, 1'b0);
        add_row(op_word(7'h00, FN_ADD, 5'd23, 5'd22, 5'd22), 5'd23, 32'h0000_000c, 1'b0);
        add_row(op_word(7'h20, FN_ADD, 5'd24, 5'd23, 5'd1), 5'd24, 32'h0000_0007, 1'b0);
        add_filler();
        add_row(op_word(7'h00, FN_ADD, 5'd25, 5'd24, 5'd23), 5'd25, 32'h0000_0013, 1'b0);
        // x0 target reports data but keeps zero
        add_row(op_imm_word(12'd7, FN_ADD, 5'd0, 5'd1), 5'd0, 32'h0000_000c, 1'b0);
        add_row(op_word(7'h00, FN_ADD, 5'd26, 5'd0, 5'd1), 5'd26, 32'h0000_0005, 1'b0);
        // Illegal opcode and bad funct7 leave their targets unchanged
        add_row({20'h00000, 5'd1, 7'b1111111}, 5'd1, 32'h0000_0000, 1'b1);
        add_row(op_word(7'h01, FN_ADD, 5'd2, 5'd1, 5'd1), 5'd2, 32'h0000_0000, 1'b1);
        add_row(op_imm_word(12'd0, FN_ADD, 5'd27, 5'd2), 5'd27, 32'hffff_fffd, 1'b0);
        add_row(op_imm_word(12'd0, FN_ADD, 5'd28, 5'd1), 5'd28, 32'h0000_0005, 1'b0);
        // Registers never written still hold their reset value
        add_row(op_word(7'h00, FN_OR, 5'd29, 5'd30, 5'd31), 5'd29, 32'h0000_0000, 1'b0);
        add_filler();
        add_filler();
        if (row_count != NUM_ROWS) begin
            $display("Instruction table holds %0d rows but %0d were expected",
                     row_count, NUM_ROWS);
            error_count++;
        end
    endtask

    ////////////////////////////////////////////////////////////////////
    // Checking
    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        check_count++;
        if (actual !== expected) begin
            $display("FAILED at %0d ns: %s, got %h, expected %h", $time, what, actual, expected);
            error_count++;
        end
    endtask

    task automatic check_row(input int r);
        int errors_before;
        errors_before = error_count;
        check_value(wb.valid, rows[r].valid, $sformatf("row %0d wb.valid", r));
        if (rows[r].valid) begin
            check_value(wb.illegal, rows[r].illegal, $sformatf("row %0d wb.illegal", r));
            check_value(wb.rd, rows[r].rd, $sformatf("row %0d wb.rd", r));
            check_value(wb.data, rows[r].data, $sformatf("row %0d wb.data", r));
        end
        test_count++;
        $display("Test %0d: %s", r, (error_count == errors_before) ? "ok" : "mismatch");
    endtask

    ////////////////////////////////////////////////////////////////////
    // Main sequence
    initial begin
        rst = 1'b1;
        fetch = '0;
        load_table();

        repeat (8) begin
            @(posedge clk);
            #2;
            check_value(wb.valid, 1'b0, "wb.valid during reset");
        end
        rst = 1'b0;

        // Row idx goes in while row idx-2 sits on wb
        for (int idx = 0; idx < NUM_ROWS + 2; idx++) begin
            @(posedge clk);
            #2;
            if (idx >= 2)
                check_row(idx - 2);
            else
                check_value(wb.valid, 1'b0, "wb.valid idle after reset");
            if (idx < NUM_ROWS) begin
                fetch.valid = rows[idx].valid;
                fetch.instruction = rows[idx].instr;
            end else begin
                fetch = '0;
            end
        end

        $display("Tests: %0d, checks: %0d, errors: %0d", test_count, check_count, error_count);
        if (error_count == 0)
            $display("Verification passed");
        else
            $display("Verification failed");
        $finish;
    end

endmodule

`default_nettype wire

//--- sources.f
+incdir+common
common/riscv_types_pkg.sv
common/core_types_pkg.sv
decode/decode_and_issue.sv
alu/alu_unit.sv
design/register_file.sv
design/rv_core.sv
tb/rv_core_tb.sv
